// File: Makefile
# Verilator build and run for the FIR filter bank testbench.

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_fir_bank -f sim.f \
		--Mdir obj_dir -o Vtb_fir_bank

run: compile
	./obj_dir/Vtb_fir_bank > sim.log 2>&1 || true
	@cat sim.log

check: run
	@if grep -qx "Test OK" sim.log; then \
		echo "Simulation passed."; \
	else \
		echo "Simulation did not pass, see sim.log."; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: fir_bank.sv
// Latency from the last channel's sample to out_valid_o is 4 + clog2(TAP_NUM). There is no stall.
`timescale 1ns/1ps
`default_nettype none

module fir_bank #(
    parameter int CH_NUM         = 2,
    parameter int TAP_NUM        = fir_pkg::DEF_TAP_NUM,
    parameter int COEF [TAP_NUM] = fir_pkg::DEF_COEF,
    parameter int OUT_SHIFT      = 17
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       en_i,
    input  logic                       sample_valid_i,
    input  fir_pkg::in_sample_t        sample_i,
    output logic                       out_valid_o,
    output fir_pkg::frame_t            out_frame_o,
    output logic [fir_pkg::MAX_CH-1:0] sat_o,
    output logic                       seq_err_o
);

    logic            frame_valid;
    fir_pkg::frame_t frame;

    wire logic [CH_NUM-1:0]  lane_valid;
    wire fir_pkg::sum_frame_t lane_sums;

    frame_assembler #(
        .CH_NUM(CH_NUM)
    ) i_frame_assembler (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .en_i          (en_i),
        .sample_valid_i(sample_valid_i),
        .sample_i      (sample_i),
        .frame_valid_o (frame_valid),
        .frame_o       (frame),
        .seq_err_o     (seq_err_o)
    );

    for (genvar n = 0; n < CH_NUM; n++) begin : g_lane
        fir_lane #(
            .TAP_NUM(TAP_NUM),
            .COEF   (COEF)
        ) i_fir_lane (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .valid_i (frame_valid),
            .sample_i(frame.smp[n]),
            .valid_o (lane_valid[n]),
            .sum_o   (lane_sums.acc[n])
        );
    end

    // Channels beyond CH_NUM have no lane.
    for (genvar n = CH_NUM; n < fir_pkg::MAX_CH; n++) begin : g_unused
        assign lane_sums.acc[n] = '0;
    end

    // All lanes run in lockstep, so lane 0 stands for the rest.
    output_scaler #(
        .CH_NUM   (CH_NUM),
        .OUT_SHIFT(OUT_SHIFT)
    ) i_output_scaler (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .valid_i(lane_valid[0]),
        .sums_i (lane_sums),
        .valid_o(out_valid_o),
        .frame_o(out_frame_o),
        .sat_o  (sat_o)
    );

endmodule

`default_nettype wire

// File: fir_lane.sv
// TAP_NUM is 1 to 32 and coefficients are cut to COEF_W bits. The delay line moves only on valid_i.
`timescale 1ns/1ps
`default_nettype none

module fir_lane #(
    parameter int TAP_NUM        = fir_pkg::DEF_TAP_NUM,
    parameter int COEF [TAP_NUM] = fir_pkg::DEF_COEF
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             valid_i,
    input  fir_pkg::sample_t sample_i,
    output logic             valid_o,
    output fir_pkg::acc_t    sum_o
);

    // Adder tree depth. The tree is padded with zero leaves up to a power of two.
    localparam int LVL    = $clog2(TAP_NUM);
    localparam int LEAVES = 1 << LVL;

    // One cycle for the delay line, one for the products, LVL for the tree.
    localparam int PIPE = 2 + LVL;

    fir_pkg::sample_t dly_q [TAP_NUM];

    // Heap order. Node 1 is the root, node k adds nodes 2k and 2k+1,
    // and the registered products sit at LEAVES to 2*LEAVES-1.
    fir_pkg::acc_t node_q [1:2*LEAVES-1];

    logic [PIPE-1:0] vld_q;

    if (TAP_NUM < 1 || TAP_NUM > 32) begin : g_tap_chk
        $error("fir_lane: TAP_NUM must be from 1 to 32, got %0d", TAP_NUM);
    end

    // Delay line, tap 0 holds the newest sample.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < TAP_NUM; i++) begin
                dly_q[i] <= '0;
            end
        end else if (valid_i) begin
            dly_q[0] <= sample_i;
            for (int i = 1; i < TAP_NUM; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    // Product stage. The products are sign-extended to the full sum width here
    // so that the tree needs no further growth.
    for (genvar k = 0; k < LEAVES; k++) begin : g_leaf
        if (k < TAP_NUM) begin : g_tap
            localparam fir_pkg::coef_t C = fir_pkg::coef_t'(COEF[k]);

            always_ff @(posedge clk_i) begin
                node_q[LEAVES+k] <= dly_q[k] * C;
            end
        end else begin : g_pad
            always_ff @(posedge clk_i) begin
                node_q[LEAVES+k] <= '0;
            end
        end
    end

    // Every internal node is one register level above its children,
    // so all paths to the root have the same latency.
    for (genvar k = 1; k < LEAVES; k++) begin : g_node
        always_ff @(posedge clk_i) begin
            node_q[k] <= node_q[2*k] + node_q[2*k+1];
        end
    end

    // Valid travels next to the data and lets frames follow each other every cycle.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[PIPE-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[PIPE-1];
    assign sum_o   = node_q[1];

endmodule

`default_nettype wire

// File: fir_pkg.sv
// Widths are fixed here for all builds. Lane sums carry 5 guard bits, which covers at most 32 taps.
`default_nettype none

package fir_pkg;

    // Sample, coefficient and lane sum widths.
    localparam int DATA_W = 16;
    localparam int COEF_W = 18;
    localparam int ACC_W  = DATA_W + COEF_W + 5;

    // The channel tag is sized for the largest bank.
    localparam int MAX_CH   = 8;
    localparam int CH_IDX_W = $clog2(MAX_CH);

    // Symmetric 8-tap low-pass. With OUT_SHIFT at 17 its DC gain is a little above one,
    // so a full-scale input can clip.
    localparam int DEF_TAP_NUM = 8;
    localparam int DEF_COEF [DEF_TAP_NUM] = '{
        -2048, 6144, 24576, 45056, 45056, 24576, 6144, -2048
    };

    typedef logic [CH_IDX_W-1:0] ch_idx_t;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // One interleaved input word.
    typedef struct packed {
        ch_idx_t ch;
        sample_t data;
    } in_sample_t;

    // Entry n holds channel n. Entries at and above the channel count stay zero.
    typedef struct packed {
        sample_t [MAX_CH-1:0] smp;
    } frame_t;

    // Full-width lane sums, one per channel.
    typedef struct packed {
        acc_t [MAX_CH-1:0] acc;
    } sum_frame_t;

endpackage

`default_nettype wire

// File: frame_assembler.sv
// Channels must arrive in order 0 to CH_NUM-1. An out-of-order sample is dropped and flagged.
`timescale 1ns/1ps
`default_nettype none

module frame_assembler #(
    parameter int CH_NUM = 2
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                en_i,
    input  logic                sample_valid_i,
    input  fir_pkg::in_sample_t sample_i,
    output logic                frame_valid_o,
    output fir_pkg::frame_t     frame_o,
    output logic                seq_err_o
);

    localparam fir_pkg::ch_idx_t LAST_CH = fir_pkg::ch_idx_t'(CH_NUM - 1);

    logic             accept;
    logic             in_order;
    logic             last;
    fir_pkg::ch_idx_t exp_ch_q;
    fir_pkg::frame_t  stage_q;
    logic             done_q;
    logic             err_q;

    if (CH_NUM < 1 || CH_NUM > fir_pkg::MAX_CH) begin : g_ch_chk
        $error("frame_assembler: CH_NUM must be from 1 to %0d, got %0d",
               fir_pkg::MAX_CH, CH_NUM);
    end

    assign accept = en_i && sample_valid_i;

    // A channel-0 sample always opens a new frame, whatever channel was expected.
    assign in_order = (sample_i.ch == '0) || (sample_i.ch == exp_ch_q);
    assign last     = (sample_i.ch == LAST_CH);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            exp_ch_q <= '0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            done_q <= accept && in_order && last;
            err_q  <= accept && !in_order;
            if (accept) begin
                if (in_order && !last) begin
                    exp_ch_q <= fir_pkg::ch_idx_t'(sample_i.ch + 1'b1);
                end else begin
                    exp_ch_q <= '0;
                end
            end
        end
    end

    // Only in-order samples reach the staging frame, so the index stays below CH_NUM.
    always_ff @(posedge clk_i) begin
        if (accept && in_order) begin
            stage_q.smp[sample_i.ch] <= sample_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            frame_valid_o <= 1'b0;
            seq_err_o     <= 1'b0;
        end else begin
            frame_valid_o <= done_q;
            seq_err_o     <= err_q;
        end
    end

    // The staging frame may already take the next channel 0 on this edge.
    // The old contents are still read here.
    always_ff @(posedge clk_i) begin
        if (done_q) begin
            for (int n = 0; n < fir_pkg::MAX_CH; n++) begin
                frame_o.smp[n] <= (n < CH_NUM) ? stage_q.smp[n] : '0;
            end
        end
    end

    // A sample either completes a frame or breaks the order, never both.
    a_valid_err_excl: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(frame_valid_o && seq_err_o)
    );

    a_exp_ch_range: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        int'(exp_ch_q) < CH_NUM
    );

endmodule

`default_nettype wire

// File: output_scaler.sv
// OUT_SHIFT must be at least 1. Rounding is half up before the arithmetic shift.
`timescale 1ns/1ps
`default_nettype none

module output_scaler #(
    parameter int CH_NUM    = 2,
    parameter int OUT_SHIFT = 17
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       valid_i,
    input  fir_pkg::sum_frame_t        sums_i,
    output logic                       valid_o,
    output fir_pkg::frame_t            frame_o,
    output logic [fir_pkg::MAX_CH-1:0] sat_o
);

    localparam fir_pkg::acc_t HALF_LSB = fir_pkg::acc_t'(1) <<< (OUT_SHIFT - 1);
    localparam fir_pkg::acc_t SMP_MAX  = fir_pkg::acc_t'(2 ** (fir_pkg::DATA_W - 1) - 1);
    localparam fir_pkg::acc_t SMP_MIN  = -SMP_MAX - 1;

    fir_pkg::frame_t            scaled;
    logic [fir_pkg::MAX_CH-1:0] clip;

    if (OUT_SHIFT < 1 || OUT_SHIFT >= fir_pkg::ACC_W) begin : g_shift_chk
        $error("output_scaler: OUT_SHIFT must be from 1 to %0d, got %0d",
               fir_pkg::ACC_W - 1, OUT_SHIFT);
    end

    always_comb begin
        fir_pkg::acc_t rnd;
        fir_pkg::acc_t shf;

        scaled = '0;
        clip   = '0;
        for (int n = 0; n < CH_NUM; n++) begin
            rnd = sums_i.acc[n] + HALF_LSB;
            shf = rnd >>> OUT_SHIFT;
            if (shf > SMP_MAX) begin
                scaled.smp[n] = SMP_MAX[fir_pkg::DATA_W-1:0];
                clip[n]       = 1'b1;
            end else if (shf < SMP_MIN) begin
                scaled.smp[n] = SMP_MIN[fir_pkg::DATA_W-1:0];
                clip[n]       = 1'b1;
            end else begin
                scaled.smp[n] = shf[fir_pkg::DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            sat_o   <= '0;
        end else begin
            valid_o <= valid_i;
            sat_o   <= valid_i ? clip : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        frame_o <= scaled;
    end

    // Saturation flags belong to a frame and never show up between frames.
    a_sat_only_valid: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !valid_o |-> (sat_o == '0)
    );

endmodule

`default_nettype wire

// File: sim.f
fir_pkg.sv
frame_assembler.sv
fir_lane.sv
output_scaler.sv
fir_bank.sv
tb_fir_bank.sv

// File: tb_fir_bank.sv
// Built for CH_NUM 2, TAP_NUM 8 and OUT_SHIFT 17 only. The model drops out-of-order channels.
`timescale 1ns/1ps
`default_nettype none

module tb_fir_bank;

    localparam int CH_NUM    = 2;
    localparam int TAP_NUM   = 8;
    localparam int OUT_SHIFT = 17;
    localparam int COEF_TB [TAP_NUM] = '{
        -2048, 6144, 24576, 45056, 45056, 24576, 6144, -2048
    };

    // The tests need about 400 cycles, so this leaves a wide margin.
    localparam int MAX_CYCLES = 2000;

    localparam longint SMP_MAX = (longint'(1) <<< (fir_pkg::DATA_W - 1)) - 1;
    localparam longint SMP_MIN = -SMP_MAX - 1;

    logic                       clk;
    logic                       rstn;
    logic                       en;
    logic                       sample_valid;
    fir_pkg::in_sample_t        sample;
    logic                       out_valid;
    fir_pkg::frame_t            out_frame;
    logic [fir_pkg::MAX_CH-1:0] sat;
    logic                       seq_err;

    int     cycle = 0;
    integer seed;

    // Software model state.
    longint                     dly_m [CH_NUM][TAP_NUM];
    longint                     stage_m [CH_NUM];
    int                         exp_ch_m;
    int                         exp_err_cnt;
    fir_pkg::frame_t            exp_frame_q [$];
    logic [fir_pkg::MAX_CH-1:0] exp_sat_q [$];

    // Monitor state.
    fir_pkg::frame_t            mon_frame;
    logic [fir_pkg::MAX_CH-1:0] mon_sat;
    int                         seen_err_cnt;
    int                         out_cnt;
    longint                     seen_ch0 [$];
    longint                     seen_ch1 [$];
    int                         seen_cyc [$];
    logic [fir_pkg::MAX_CH-1:0] last_sat;
    longint                     last_ch0;

    fir_bank #(
        .CH_NUM   (CH_NUM),
        .TAP_NUM  (TAP_NUM),
        .COEF     (COEF_TB),
        .OUT_SHIFT(OUT_SHIFT)
    ) i_fir_bank (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .en_i          (en),
        .sample_valid_i(sample_valid),
        .sample_i      (sample),
        .out_valid_o   (out_valid),
        .out_frame_o   (out_frame),
        .sat_o         (sat),
        .seq_err_o     (seq_err)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_eq(input string sig, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, sig, got, exp);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing.", MAX_CYCLES);
            stop_with_failure();
        end
    end

    // Filters one completed frame through the per-channel delay lines.
    task automatic model_frame();
        fir_pkg::frame_t            f;
        logic [fir_pkg::MAX_CH-1:0] s;
        longint                     acc;

        f = '0;
        s = '0;
        for (int n = 0; n < CH_NUM; n++) begin
            for (int k = TAP_NUM - 1; k > 0; k--) begin
                dly_m[n][k] = dly_m[n][k-1];
            end
            dly_m[n][0] = stage_m[n];
            acc = 0;
            for (int k = 0; k < TAP_NUM; k++) begin
                acc += dly_m[n][k] * COEF_TB[k];
            end
            acc = (acc + (longint'(1) <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
            if (acc > SMP_MAX) begin
                f.smp[n] = fir_pkg::sample_t'(SMP_MAX);
                s[n]     = 1'b1;
            end else if (acc < SMP_MIN) begin
                f.smp[n] = fir_pkg::sample_t'(SMP_MIN);
                s[n]     = 1'b1;
            end else begin
                f.smp[n] = fir_pkg::sample_t'(acc);
            end
        end
        exp_frame_q.push_back(f);
        exp_sat_q.push_back(s);
    endtask

    task automatic model_strobe(input int ch, input int data, input bit enable);
        if (enable) begin
            if (ch != 0 && ch != exp_ch_m) begin
                exp_err_cnt++;
                exp_ch_m = 0;
            end else begin
                stage_m[ch] = data;
                if (ch == CH_NUM - 1) begin
                    model_frame();
                    exp_ch_m = 0;
                end else begin
                    exp_ch_m = ch + 1;
                end
            end
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge.
    task automatic send_sample(input int ch, input int data, input bit enable);
        sample_valid = 1'b1;
        en           = enable;
        sample.ch    = fir_pkg::ch_idx_t'(ch);
        sample.data  = fir_pkg::sample_t'(data);
        model_strobe(ch, data, enable);
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
        en           = 1'b1;
    endtask

    task automatic send_frame(input int d0, input int d1);
        send_sample(0, d0, 1'b1);
        send_sample(1, d1, 1'b1);
    endtask

    task automatic wait_drain();
        while (exp_frame_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change.
    always @(negedge clk) begin
        if (rstn) begin
            if (seq_err) begin
                seen_err_cnt++;
            end
            if (out_valid) begin
                if (exp_frame_q.size() == 0) begin
                    $display("An output frame appeared at %0d ns with none expected.", $time);
                    stop_with_failure();
                end else begin
                    mon_frame = exp_frame_q.pop_front();
                    mon_sat   = exp_sat_q.pop_front();
                    for (int n = 0; n < fir_pkg::MAX_CH; n++) begin
                        check_eq($sformatf("out_frame_o.smp[%0d]", n),
                                 out_frame.smp[n], mon_frame.smp[n]);
                    end
                    check_eq("sat_o", sat, mon_sat);
                    out_cnt++;
                    seen_ch0.push_back(out_frame.smp[0]);
                    seen_ch1.push_back(out_frame.smp[1]);
                    seen_cyc.push_back(cycle);
                    last_sat = sat;
                    last_ch0 = out_frame.smp[0];
                end
            end else begin
                check_eq("sat_o", sat, 0);
            end
        end
    end

    task automatic test_idle();
        repeat (20) begin
            @(negedge clk);
            check_eq("out_valid_o", out_valid, 0);
            check_eq("sat_o", sat, 0);
            check_eq("seq_err_o", seq_err, 0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_impulse();
        int     acc_cyc;
        longint exp_val;

        seen_ch0.delete();
        seen_ch1.delete();
        seen_cyc.delete();
        send_frame(32767, 0);
        acc_cyc = cycle;
        repeat (TAP_NUM) send_frame(0, 0);
        wait_drain();
        check_eq("output frame count", seen_ch0.size(), TAP_NUM + 1);
        check_eq("out_valid_o latency", seen_cyc[0] - acc_cyc, 7);
        for (int k = 0; k < TAP_NUM; k++) begin
            exp_val = (longint'(32767) * COEF_TB[k] + (longint'(1) <<< (OUT_SHIFT - 1)))
                      >>> OUT_SHIFT;
            check_eq($sformatf("out_frame_o.smp[0] tap %0d", k), seen_ch0[k], exp_val);
            check_eq("out_frame_o.smp[1]", seen_ch1[k], 0);
        end
    endtask

    task automatic test_saturation();
        int d0;

        for (int j = 0; j < TAP_NUM; j++) begin
            d0 = (COEF_TB[TAP_NUM-1-j] < 0) ? -32768 : 32767;
            send_frame(d0, 0);
        end
        wait_drain();
        check_eq("sat_o", last_sat, 1);
        check_eq("out_frame_o.smp[0]", last_ch0, SMP_MAX);
    endtask

    task automatic test_seq_error();
        int err_before;
        int out_before;

        err_before = seen_err_cnt;
        out_before = out_cnt;
        send_sample(1, 1234, 1'b1);
        send_frame(500, -700);
        wait_drain();
        check_eq("seq_err_o pulses", seen_err_cnt - err_before, 1);
        check_eq("seq_err_o total", seen_err_cnt, exp_err_cnt);
        check_eq("output frame count", out_cnt - out_before, 1);
    endtask

    task automatic test_random_stream();
        logic [31:0]      rnd_word;
        fir_pkg::sample_t data;

        seed = 32'hba64;
        for (int f = 0; f < 100; f++) begin
            for (int ch = 0; ch < CH_NUM; ch++) begin
                rnd_word = $random(seed);
                data     = rnd_word[15:0];
                // About one strobe in eight is first repeated with en_i low.
                if (rnd_word[20:18] == 3'd0) begin
                    send_sample(ch, int'(-data), 1'b0);
                end
                send_sample(ch, int'(data), 1'b1);
            end
        end
        wait_drain();
        check_eq("seq_err_o total", seen_err_cnt, exp_err_cnt);
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        en           = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        exp_ch_m     = 0;
        exp_err_cnt  = 0;
        seen_err_cnt = 0;
        out_cnt      = 0;
        for (int n = 0; n < CH_NUM; n++) begin
            stage_m[n] = 0;
            for (int k = 0; k < TAP_NUM; k++) begin
                dly_m[n][k] = 0;
            end
        end

        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        en   = 1'b1;

        test_idle();
        test_impulse();
        test_saturation();
        test_seq_error();
        test_random_stream();

        if (exp_frame_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d expected frames never came out.", exp_frame_q.size());
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
